//--- tb/mc_bus_vectors.txt
// op master adr dat sel exp, hex, one token per line
// op 0 write, 1 read, 2 io hit, 3 io miss, 4 rk+my dma, 5 sd single, 6 sd all, f end
// cpu ram, both lanes then single lanes (word 000400 octal)
0_0_0100_1234_3_0000
1_0_0100_0000_3_1234
0_0_0100_abcd_1_0000
1_0_0100_0000_3_12cd
0_0_0100_5600_2_0000
1_0_0100_0000_3_56cd
// top of ram, 157776 octal
0_0_dffe_beef_3_0000
1_0_dffe_0000_3_beef
// i/o page, exp = io_sel vector
2_0_ff70_0000_3_0080
2_0_fd44_0000_3_0040
2_0_ff4e_0000_3_0020
2_0_ff0a_0000_3_0010
2_0_f81e_0000_3_0008
2_0_fe7a_0000_3_0004
2_0_f462_0000_3_0002
2_0_fda6_0000_3_0001
// 177000 octal hits nothing
3_0_fe00_0000_3_0000
// dma writes, sel forced to both lanes
0_1_0200_1111_1_0000
1_0_0200_0000_3_1111
0_2_0202_2222_2_0000
1_0_0202_0000_3_2222
// rk and my together, my writes exp to adr+2
4_0_0300_aaaa_3_bbbb
1_0_0300_0000_3_aaaa
1_0_0302_0000_3_bbbb
// sd, exp = lines of that user
5_1_0000_0000_0_0001
5_3_0000_0000_0_0003
6_0_0000_0000_0_0123
f_0_0000_0000_0_0000

//--- project.f
source/mc_bus_pkg.sv
source/bus_master_arbiter.sv
source/io_page_decoder.sv
source/main_memory.sv
source/sd_access_arbiter.sv
source/mc_bus_top.sv
tb/mc_bus_checker.sv
tb/tb_mc_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mc_bus
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_mc_bus.sv
// mc bus core testbench
`timescale 1ns/1ps

module tb_mc_bus;
   import mc_bus_pkg::*;

   localparam int          WAIT_LIMIT  = 50;      // cycles per wait loop
   localparam int          MISS_WAIT   = 20;      // no-ack window for a miss
   localparam int          VEC_MAX     = 64;
   localparam logic [7:0]  LFSR_SEED   = 8'd56;
   localparam logic [15:0] IO_DAT_BASE = 16'hd000; // model data = base | index

   logic                        clk_sys;
   logic                        rst_n_i;
   bus_req_t                    cpu_req, rk_req, my_req;
   bus_rsp_t                    cpu_rsp, rk_rsp, my_rsp;
   logic                        cpu_gnt, rk_gnt, my_gnt;
   io_sel_t                     io_sel;
   bus_req_t                    io_bus;
   logic [N_IO-1:0][DATA_W-1:0] io_dat;
   logic [N_IO-1:0]             io_ack;
   sd_vec_t                     sd_req, sd_gnt;
   spi_lines_t                  sd_lines [N_SD];
   spi_lines_t                  sd_card;

   logic [59:0] vec_mem [VEC_MAX];   // op, master, adr, dat, sel, exp
   logic [7:0]  lfsr_q;
   logic        io_busy;             // slave model state
   int          io_wait;

   mc_bus_top uut (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i),
      .cpu_req_i(cpu_req), .rk_dma_req_i(rk_req), .my_dma_req_i(my_req),
      .cpu_rsp_o(cpu_rsp), .rk_dma_rsp_o(rk_rsp), .my_dma_rsp_o(my_rsp),
      .cpu_gnt_o(cpu_gnt), .rk_dma_gnt_o(rk_gnt), .my_dma_gnt_o(my_gnt),
      .io_sel_o(io_sel), .io_bus_o(io_bus), .io_dat_i(io_dat), .io_ack_i(io_ack),
      .sd_req_i(sd_req), .sd_lines_i(sd_lines), .sd_gnt_o(sd_gnt), .sd_card_o(sd_card)
   );

   bind bus_master_arbiter mc_bus_checker u_bus_chk (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i), .cpu_gnt(cpu_gnt_o), .rk_gnt(rk_dma_gnt_o),
      .my_gnt(my_dma_gnt_o), .bus_cyc(sys_bus_o.cyc), .sd_gnt('0)
   );
   bind sd_access_arbiter mc_bus_checker u_sd_chk (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i), .cpu_gnt(1'b1), .rk_gnt(1'b0),
      .my_gnt(1'b0), .bus_cyc(1'b0), .sd_gnt(sd_gnt_o)
   );

   initial begin
      clk_sys = 1'b0;
      forever #5 clk_sys = ~clk_sys;   // 100 MHz
   end

   //****************************************
   // error handling and compares
   //****************************************
   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("[ERROR] %0t ns: %s", $time, msg));
   endtask

   task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
      if (got !== exp) report_mismatch($sformatf("%s rsp %h, expected %h", what, got, exp));
   endtask

   task automatic check_bus(input bus_req_t got, input bus_req_t exp, input string what);
      if (got !== exp) report_mismatch($sformatf("%s bus %h, expected %h", what, got, exp));
   endtask

   task automatic check_sel(input io_sel_t got, input io_sel_t exp, input string what);
      if (got !== exp) report_mismatch($sformatf("%s io_sel %b, expected %b", what, got, exp));
   endtask

   task automatic check_lines(input spi_lines_t got, input spi_lines_t exp, input string what);
      if (got !== exp) report_mismatch($sformatf("%s card %b, expected %b", what, got, exp));
   endtask

   task automatic check_sd_gnt(input sd_vec_t got, input sd_vec_t exp, input string what);
      if (got !== exp) report_mismatch($sformatf("%s sd_gnt %b, expected %b", what, got, exp));
   endtask

   task automatic check_grant(input logic got, input logic exp, input string what);
      if (got !== exp) report_mismatch($sformatf("%s grant %b, expected %b", what, got, exp));
   endtask

   //****************************************
   // lfsr and i/o slave model
   //****************************************
   // x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic draw_delay(output int d);
      d = 0;
      for (int b = 0; b < 2; b++) begin   // one step per bit
         lfsr_q = lfsr_step(lfsr_q);
         d = (d << 1) | lfsr_q[0];
      end
   endtask

   always @(posedge clk_sys) begin
      if (!rst_n_i || io_sel == '0) begin
         io_ack  <= '0;
         io_busy = 1'b0;
      end else if (!io_busy) begin
         io_busy = 1'b1;
         draw_delay(io_wait);   // 0..3 cycles
      end else if (io_wait == 0) begin
         io_ack <= io_sel;      // ack the selected device
      end else begin
         io_wait = io_wait - 1;
      end
   end

   //****************************************
   // bus master helpers
   //****************************************
   task automatic drive_master(input int m, input bus_req_t r);
      case (m)
         0: cpu_req <= r;
         1: rk_req  <= r;
         default: my_req <= r;
      endcase
   endtask

   function automatic bus_rsp_t rsp_of(input int m);
      return (m == 0) ? cpu_rsp : ((m == 1) ? rk_rsp : my_rsp);
   endfunction

   function automatic logic gnt_of(input int m);
      return (m == 0) ? cpu_gnt : ((m == 1) ? rk_gnt : my_gnt);
   endfunction

   // one transfer, master holds cyc/stb until ack or limit
   task automatic bus_xfer(input int m, input logic we, input logic [1:0] sel,
                           input logic [15:0] adr, input logic [15:0] dat, input int limit,
                           output bus_rsp_t rsp, output io_sel_t sel_seen,
                           output bus_req_t bus_seen,
                           output logic gnt_seen, output logic cpu_gnt_seen,
                           output logic done);
      bus_req_t r;
      int       cnt;
      r = '0;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      r.we  = we;
      r.sel = sel;
      r.adr = adr;
      r.dat = dat;
      done = 1'b0;
      cnt = 0;
      sel_seen = '0;
      bus_seen = '0;
      gnt_seen = 1'b0;
      cpu_gnt_seen = 1'b0;
      @(posedge clk_sys);
      drive_master(m, r);
      while (!done && cnt < limit) begin
         @(negedge clk_sys);   // sample away from the edge
         cnt++;
         rsp = rsp_of(m);
         if (io_sel != '0) sel_seen = io_sel;
         if (rsp.ack) begin
            done = 1'b1;
            bus_seen = io_bus;     // what the devices saw
            gnt_seen = gnt_of(m);
            cpu_gnt_seen = cpu_gnt;
         end
      end
      @(posedge clk_sys);
      drive_master(m, '0);     // drop after ack
      @(posedge clk_sys);
   endtask

   // wait until the card is held (want = 1) or free (want = 0)
   task automatic wait_sd(input logic want, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk_sys);
         cycles++;
         if (cycles > WAIT_LIMIT) abort_run("timeout waiting for an sd grant change");
      end while ((sd_gnt != '0) != want);
   endtask

   task automatic wait_ack(input int m, input string what);
      int cnt;
      cnt = 0;
      do begin
         @(negedge clk_sys);
         cnt++;
         if (m == 2 && my_gnt && rk_rsp.ack) report_mismatch("rk ack while my owns the bus");
         if (m == 1 && my_gnt) report_mismatch("my granted during rk transfer");
         if (cnt > WAIT_LIMIT) abort_run($sformatf("timeout waiting for %s ack", what));
      end while (!rsp_of(m).ack);
   endtask

   //****************************************
   // main sequence
   //****************************************
   initial begin
      logic [3:0]  op, mst;
      logic [15:0] adr, dat, exp;
      logic [1:0]  sel;
      bus_rsp_t    rsp;
      bus_req_t    obs_bus;
      io_sel_t     seen;
      logic        gs, cgs, done;
      int          cyc, idx, usr;

      rst_n_i = 1'b0;
      cpu_req = '0;
      rk_req  = '0;
      my_req  = '0;
      io_ack  = '0;
      sd_req  = '0;
      lfsr_q  = LFSR_SEED;
      io_busy = 1'b0;
      io_wait = 0;
      for (int i = 0; i < N_IO; i++) io_dat[i] = IO_DAT_BASE | 16'(i);
      for (int i = 0; i < N_SD; i++) sd_lines[i] = spi_lines_t'(i);
      $readmemh("tb/mc_bus_vectors.txt", vec_mem);

      repeat (10) @(posedge clk_sys);
      rst_n_i <= 1'b1;
      @(negedge clk_sys);
      check_grant(cpu_gnt, 1'b1, "reset cpu");
      check_grant(rk_gnt | my_gnt, 1'b0, "reset dma");
      check_rsp(cpu_rsp, '{dat: '0, ack: 1'b0}, "reset cpu");   // nothing selected
      check_rsp(rk_rsp, '{dat: '0, ack: 1'b0}, "reset rk");
      check_rsp(my_rsp, '{dat: '0, ack: 1'b0}, "reset my");
      check_sd_gnt(sd_gnt, '0, "reset");
      check_lines(sd_card, 3'b110, "reset");   // cs 1, mosi 1, sclk 0

      for (int v = 0; v < VEC_MAX; v++) begin
         if ((^vec_mem[v]) === 1'bx) abort_run("vector file has no end marker");
         {op, mst, adr, dat} = vec_mem[v][59:20];
         sel = vec_mem[v][17:16];
         exp = vec_mem[v][15:0];
         if (op == 4'hf) break;
         case (op)
            4'h0, 4'h1: begin   // write or read
               bus_xfer(mst, op == 4'h0, sel, adr, dat, WAIT_LIMIT,
                        rsp, seen, obs_bus, gs, cgs, done);
               if (!done) abort_run($sformatf("timeout on bus transfer at vector %0d", v));
               // dma always moves both lanes
               check_bus(obs_bus, '{cyc: 1'b1, stb: 1'b1, we: op == 4'h0,
                                    sel: (mst != 0) ? 2'b11 : sel, adr: adr, dat: dat},
                         "xfer");
               if (mst != 0) begin
                  check_grant(gs, 1'b1, "dma owner");
                  check_grant(cgs, 1'b0, "cpu during dma");
               end
               if (op == 4'h1) check_rsp(rsp, '{dat: exp, ack: 1'b1}, "read");
            end
            4'h2: begin         // i/o page hit
               bus_xfer(0, 1'b0, sel, adr, dat, WAIT_LIMIT, rsp, seen, obs_bus, gs, cgs, done);
               if (!done) abort_run($sformatf("timeout on i/o access at vector %0d", v));
               check_sel(seen, io_sel_t'(exp[7:0]), "io");
               check_bus(obs_bus, '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: sel, adr: adr,
                                    dat: dat}, "io");
               idx = 0;
               for (int i = 0; i < N_IO; i++) if (exp[i]) idx = i;
               check_rsp(rsp, '{dat: IO_DAT_BASE | 16'(idx), ack: 1'b1}, "io");
            end
            4'h3: begin         // i/o page miss
               bus_xfer(0, 1'b0, sel, adr, dat, MISS_WAIT, rsp, seen, obs_bus, gs, cgs, done);
               if (done) report_mismatch("ack on an unmapped i/o address");
               check_sel(seen, '0, "miss");
            end
            4'h4: begin         // rk and my in the same idle cycle
               @(posedge clk_sys);
               rk_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: 2'b11, adr: adr, dat: dat};
               my_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: 2'b11,
                           adr: adr + 16'd2, dat: exp};
               wait_ack(1, "rk");
               @(posedge clk_sys);
               rk_req <= '0;
               wait_ack(2, "my");
               check_grant(my_gnt, 1'b1, "my after rk");
               @(posedge clk_sys);
               my_req <= '0;
               @(posedge clk_sys);
            end
            4'h5: begin         // single sd user
               @(posedge clk_sys);
               sd_req[mst] <= 1'b1;
               @(negedge clk_sys);   // request visible from here
               wait_sd(1'b1, cyc);
               if (cyc != 3) report_mismatch($sformatf("sd grant after %0d cycles", cyc));
               check_sd_gnt(sd_gnt, sd_vec_t'(1 << mst), "single");
               check_lines(sd_card, spi_lines_t'(exp[2:0]), "single");
               @(posedge clk_sys);
               sd_req[mst] <= 1'b0;
               @(negedge clk_sys);
               wait_sd(1'b0, cyc);
               if (cyc != 3) report_mismatch($sformatf("sd release after %0d cycles", cyc));
               check_lines(sd_card, 3'b110, "release");
            end
            4'h6: begin         // all users at once, exp lists the order
               @(posedge clk_sys);
               sd_req <= '1;
               for (int k = 3; k >= 0; k--) begin
                  usr = exp[4*k +: 4];
                  wait_sd(1'b1, cyc);
                  check_sd_gnt(sd_gnt, sd_vec_t'(1 << usr), "priority");
                  check_lines(sd_card, spi_lines_t'(usr), "priority");
                  @(posedge clk_sys);
                  sd_req[usr] <= 1'b0;
                  wait_sd(1'b0, cyc);
               end
            end
            default: abort_run($sformatf("unknown operation %h at vector %0d", op, v));
         endcase
      end

      $display("All tests passed");
      $finish;
   end

endmodule

//--- tb/mc_bus_checker.sv
// bus and card grant assertions
`timescale 1ns/1ps

module mc_bus_checker
   import mc_bus_pkg::*;
(
   input logic    clk_sys,
   input logic    rst_n_i,
   input logic    cpu_gnt,
   input logic    rk_gnt,
   input logic    my_gnt,
   input logic    bus_cyc,   // shared cyc
   input sd_vec_t sd_gnt
);

   //****************************************
   // system bus ownership
   //****************************************
   a_one_dma: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      !(rk_gnt && my_gnt))
      else $error("both dma grants high");

   a_cpu_default: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      cpu_gnt == !(rk_gnt || my_gnt))
      else $error("cpu grant disagrees with dma grants");

   // ownership frozen while a cycle is open
   a_frozen: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      bus_cyc |=> $stable({rk_gnt, my_gnt}))
      else $error("grant changed during an open cycle");

   //****************************************
   // sd card grants
   //****************************************
   a_sd_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      $onehot0(sd_gnt))
      else $error("sd grant not one-hot");

   a_sd_no_steal: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      (sd_gnt != '0) |=> ((sd_gnt & ~$past(sd_gnt)) == '0))
      else $error("new sd grant while card held");

endmodule

//--- source/mc_bus_top.sv
// mc bus core top level
`timescale 1ns/1ps

module mc_bus_top
   import mc_bus_pkg::*;
(
   input  logic                         clk_sys,
   input  logic                         rst_n_i,

   // bus masters
   input  bus_req_t                     cpu_req_i,
   input  bus_req_t                     rk_dma_req_i,
   input  bus_req_t                     my_dma_req_i,
   output bus_rsp_t                     cpu_rsp_o,
   output bus_rsp_t                     rk_dma_rsp_o,
   output bus_rsp_t                     my_dma_rsp_o,
   output logic                         cpu_gnt_o,
   output logic                         rk_dma_gnt_o,
   output logic                         my_dma_gnt_o,

   // i/o page slave port
   output io_sel_t                      io_sel_o,
   output bus_req_t                     io_bus_o,
   input  logic [N_IO-1:0][DATA_W-1:0]  io_dat_i,
   input  logic [N_IO-1:0]              io_ack_i,

   // sd card users
   input  sd_vec_t                      sd_req_i,
   input  spi_lines_t                   sd_lines_i [N_SD],
   output sd_vec_t                      sd_gnt_o,
   output spi_lines_t                   sd_card_o
);

   bus_req_t          sys_bus;    // granted master's request
   bus_rsp_t          sys_rsp;    // merged answer
   logic              ram_stb;
   logic [DATA_W-1:0] ram_dat;
   logic              ram_ack;

   assign io_bus_o = sys_bus;    // devices see the shared bus

   //****************************************
   // system bus
   //****************************************
   bus_master_arbiter u_master_arb (
      .clk_sys      (clk_sys),
      .rst_n_i      (rst_n_i),
      .cpu_req_i    (cpu_req_i),
      .rk_dma_req_i (rk_dma_req_i),
      .my_dma_req_i (my_dma_req_i),
      .sys_rsp_i    (sys_rsp),
      .sys_bus_o    (sys_bus),
      .cpu_rsp_o    (cpu_rsp_o),
      .rk_dma_rsp_o (rk_dma_rsp_o),
      .my_dma_rsp_o (my_dma_rsp_o),
      .cpu_gnt_o    (cpu_gnt_o),
      .rk_dma_gnt_o (rk_dma_gnt_o),
      .my_dma_gnt_o (my_dma_gnt_o)
   );

   io_page_decoder u_decoder (
      .sys_bus_i (sys_bus),
      .ram_dat_i (ram_dat),
      .ram_ack_i (ram_ack),
      .io_dat_i  (io_dat_i),
      .io_ack_i  (io_ack_i),
      .ram_stb_o (ram_stb),
      .io_sel_o  (io_sel_o),
      .sys_rsp_o (sys_rsp)
   );

   main_memory u_ram (
      .clk_sys   (clk_sys),
      .rst_n_i   (rst_n_i),
      .sys_bus_i (sys_bus),
      .ram_stb_i (ram_stb),
      .ram_dat_o (ram_dat),
      .ram_ack_o (ram_ack)
   );

   //****************************************
   // sd card dispatcher
   //****************************************
   sd_access_arbiter u_sd_arb (
      .clk_sys    (clk_sys),
      .rst_n_i    (rst_n_i),
      .sd_req_i   (sd_req_i),
      .sd_lines_i (sd_lines_i),
      .sd_gnt_o   (sd_gnt_o),
      .sd_card_o  (sd_card_o)
   );

endmodule

//--- source/sd_access_arbiter.sv
// sd card access dispatcher
`timescale 1ns/1ps

module sd_access_arbiter
   import mc_bus_pkg::*;
(
   input  logic       clk_sys,
   input  logic       rst_n_i,
   input  sd_vec_t    sd_req_i,            // request per controller
   input  spi_lines_t sd_lines_i [N_SD],   // each controller's card lines
   output sd_vec_t    sd_gnt_o,
   output spi_lines_t sd_card_o            // to the card
);

   //****************************************
   // request filters
   //****************************************
   logic [SD_FILTER_DEPTH-1:0] req_sh_q [N_SD];   // shift per user
   sd_vec_t                    req_f;             // filtered requests
   sd_vec_t                    gnt_q;             // one-hot or zero

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         for (int i = 0; i < N_SD; i++) begin
            req_sh_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_SD; i++) begin
            // new sample in at bit 0
            req_sh_q[i] <= {req_sh_q[i][SD_FILTER_DEPTH-2:0], sd_req_i[i]};
         end
      end
   end

   always_comb begin
      for (int i = 0; i < N_SD; i++) begin
         req_f[i] = req_sh_q[i][SD_FILTER_DEPTH-1];   // last stage
      end
   end

   //****************************************
   // grant state
   //****************************************
   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         gnt_q <= '0;
      end else if (gnt_q == '0) begin
         // card free, fixed priority scan
         if (req_f[SD_RK]) begin
            gnt_q[SD_RK] <= 1'b1;
         end else if (req_f[SD_DW]) begin
            gnt_q[SD_DW] <= 1'b1;
         end else if (req_f[SD_DX]) begin
            gnt_q[SD_DX] <= 1'b1;
         end else if (req_f[SD_MY]) begin
            gnt_q[SD_MY] <= 1'b1;
         end
      end else if ((gnt_q & req_f) == '0) begin
         gnt_q <= '0;   // holder let go, free for one cycle
      end
   end

   assign sd_gnt_o = gnt_q;

   //****************************************
   // card line mux
   //****************************************
   always_comb begin
      sd_card_o.cs   = SD_DEF_CS;     // nobody holds the card
      sd_card_o.mosi = SD_DEF_MOSI;
      sd_card_o.sclk = SD_DEF_SCLK;
      for (int i = 0; i < N_SD; i++) begin
         if (gnt_q[i]) begin
            sd_card_o = sd_lines_i[i];   // grant is one-hot
         end
      end
   end

endmodule

//--- source/main_memory.sv
// main memory with byte lanes
`timescale 1ns/1ps

module main_memory
   import mc_bus_pkg::*;
(
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  bus_req_t          sys_bus_i,   // shared bus
   input  logic              ram_stb_i,   // from the decoder
   output logic [DATA_W-1:0] ram_dat_o,
   output logic              ram_ack_o
);

   logic [DATA_W-1:0] mem_q [2**MEM_AW];   // word storage
   logic [MEM_AW-1:0] word_adr;            // byte address without bit 0

   assign word_adr = sys_bus_i.adr[ADDR_W-1:1];

   // write per lane, read registered
   always_ff @(posedge clk_sys) begin
      if (ram_stb_i) begin
         if (sys_bus_i.we) begin
            if (sys_bus_i.sel[0]) begin
               mem_q[word_adr][7:0] <= sys_bus_i.dat[7:0];     // low byte
            end
            if (sys_bus_i.sel[1]) begin
               mem_q[word_adr][15:8] <= sys_bus_i.dat[15:8];   // high byte
            end
         end
         ram_dat_o <= mem_q[word_adr];   // old contents on a write
      end
   end

   // ack one cycle behind the strobe, held while it stays up
   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         ram_ack_o <= 1'b0;
      end else begin
         ram_ack_o <= ram_stb_i;
      end
   end

endmodule

//--- source/io_page_decoder.sv
// i/o page address decoder
`timescale 1ns/1ps

module io_page_decoder
   import mc_bus_pkg::*;
(
   input  bus_req_t                     sys_bus_i,   // shared bus
   input  logic [DATA_W-1:0]            ram_dat_i,
   input  logic                         ram_ack_i,
   input  logic [N_IO-1:0][DATA_W-1:0]  io_dat_i,    // index = io_sel_o bit
   input  logic [N_IO-1:0]              io_ack_i,

   output logic                         ram_stb_o,
   output io_sel_t                      io_sel_o,
   output bus_rsp_t                     sys_rsp_o
);

   logic              bus_act;   // live transfer on the bus
   logic [N_IO-1:0]   sel_vec;   // io_sel_o as a plain vector
   logic [DATA_W-1:0] io_mux;    // or of selected device data

   // compare address above the span bits against a base
   function automatic logic hit(
      input logic [ADDR_W-1:0] adr,
      input logic [ADDR_W-1:0] base,
      input int unsigned       span
   );
      return (adr >> span) == (base >> span);
   endfunction

   assign bus_act = sys_bus_i.stb & sys_bus_i.cyc;

   //****************************************
   // selects
   //****************************************
   // main memory, everything below 160000
   assign ram_stb_o = bus_act & (sys_bus_i.adr[ADDR_W-1 -: 3] != RAM_TOP_BITS);

   always_comb begin
      io_sel_o.uart1 = bus_act & hit(sys_bus_i.adr, UART1_BASE, UART1_SPAN); // 177560-177566
      io_sel_o.uart2 = bus_act & hit(sys_bus_i.adr, UART2_BASE, UART2_SPAN); // 176500-176506
      io_sel_o.lpt   = bus_act & hit(sys_bus_i.adr, LPT_BASE, LPT_SPAN);     // 177514-177516
      io_sel_o.rk    = bus_act & hit(sys_bus_i.adr, RK_BASE, RK_SPAN);       // 177400-177416
      io_sel_o.dw    = bus_act & hit(sys_bus_i.adr, DW_BASE, DW_SPAN);       // 174000-174036
      io_sel_o.rx    = bus_act & hit(sys_bus_i.adr, RX_BASE, RX_SPAN);       // 177170-177172
      io_sel_o.my    = bus_act & hit(sys_bus_i.adr, MY_BASE, MY_SPAN);       // 172140-172142
      io_sel_o.kgd   = bus_act & hit(sys_bus_i.adr, KGD_BASE, KGD_SPAN);     // 176640-176646
   end

   assign sel_vec = io_sel_o;

   //****************************************
   // read data and ack
   //****************************************
   always_comb begin
      io_mux = '0;
      for (int i = 0; i < N_IO; i++) begin
         if (sel_vec[i]) begin
            io_mux = io_mux | io_dat_i[i];   // only the selected one
         end
      end
   end

   // unselected sources contribute zeros
   assign sys_rsp_o.dat = (ram_stb_o ? ram_dat_i : '0) | io_mux;

   // acks from all sources wired together
   assign sys_rsp_o.ack = ram_ack_i | (|io_ack_i);

endmodule

//--- source/bus_master_arbiter.sv
// bus master arbiter and switch
`timescale 1ns/1ps

module bus_master_arbiter
   import mc_bus_pkg::*;
(
   input  logic     clk_sys,
   input  logic     rst_n_i,         // sync, active low

   input  bus_req_t cpu_req_i,       // processor
   input  bus_req_t rk_dma_req_i,    // rk dma engine, cyc = request
   input  bus_req_t my_dma_req_i,    // my dma engine, cyc = request
   input  bus_rsp_t sys_rsp_i,       // from decoder

   output bus_req_t sys_bus_o,       // shared bus
   output bus_rsp_t cpu_rsp_o,
   output bus_rsp_t rk_dma_rsp_o,
   output bus_rsp_t my_dma_rsp_o,
   output logic     cpu_gnt_o,       // processor owns the bus
   output logic     rk_dma_gnt_o,
   output logic     my_dma_gnt_o
);

   //****************************************
   // ownership state
   //****************************************
   logic rk_own_q;   // rk holds the bus
   logic my_own_q;   // my holds the bus

   always_ff @(posedge clk_sys) begin
      if (!rst_n_i) begin
         rk_own_q <= 1'b0;
         my_own_q <= 1'b0;
      end else if (!sys_bus_o.cyc) begin   // switch only between cycles
         if (rk_dma_req_i.cyc) begin       // rk beats my
            rk_own_q <= 1'b1;
            my_own_q <= 1'b0;
         end else if (my_dma_req_i.cyc) begin
            rk_own_q <= 1'b0;
            my_own_q <= 1'b1;
         end else begin
            // no dma pending, bus back to the processor
            rk_own_q <= 1'b0;
            my_own_q <= 1'b0;
         end
      end
   end

   assign rk_dma_gnt_o = rk_own_q;
   assign my_dma_gnt_o = my_own_q;
   assign cpu_gnt_o    = ~(rk_own_q | my_own_q);   // default owner

   //****************************************
   // request switch
   //****************************************
   always_comb begin
      sys_bus_o = cpu_req_i;
      if (rk_own_q) begin
         sys_bus_o     = rk_dma_req_i;
         sys_bus_o.sel = '1;               // dma moves whole words
      end else if (my_own_q) begin
         sys_bus_o     = my_dma_req_i;
         sys_bus_o.sel = '1;
      end
   end

   //****************************************
   // response routing
   //****************************************
   // data goes everywhere, ack only to the owner
   always_comb begin
      cpu_rsp_o        = sys_rsp_i;
      cpu_rsp_o.ack    = sys_rsp_i.ack & cpu_gnt_o;
      rk_dma_rsp_o     = sys_rsp_i;
      rk_dma_rsp_o.ack = sys_rsp_i.ack & rk_own_q;
      my_dma_rsp_o     = sys_rsp_i;
      my_dma_rsp_o.ack = sys_rsp_i.ack & my_own_q;
   end

endmodule

//--- source/mc_bus_pkg.sv
// mc bus shared definitions
package mc_bus_pkg;

   //****************************************
   // widths
   //****************************************
   localparam int unsigned ADDR_W = 16;   // bus address
   localparam int unsigned DATA_W = 16;   // bus data
   localparam int unsigned SEL_W  = 2;    // byte lanes
   localparam int unsigned MEM_AW = 15;   // ram word address, adr[15:1]

   //****************************************
   // address map
   //****************************************
   // top three bits all ones = i/o page, ram lives below 160000
   localparam logic [2:0] RAM_TOP_BITS = 3'o7;

   localparam logic [ADDR_W-1:0] UART1_BASE = 16'o177560;  // console port
   localparam logic [ADDR_W-1:0] UART2_BASE = 16'o176500;  // second serial port
   localparam logic [ADDR_W-1:0] LPT_BASE   = 16'o177514;  // printer
   localparam logic [ADDR_W-1:0] RK_BASE    = 16'o177400;  // rk disk
   localparam logic [ADDR_W-1:0] DW_BASE    = 16'o174000;  // dw hard disk
   localparam logic [ADDR_W-1:0] RX_BASE    = 16'o177170;  // rx01 floppy
   localparam logic [ADDR_W-1:0] MY_BASE    = 16'o172140;  // my floppy
   localparam logic [ADDR_W-1:0] KGD_BASE   = 16'o176640;  // graphics

   // low address bits ignored by each device
   localparam int unsigned UART1_SPAN = 3;
   localparam int unsigned UART2_SPAN = 3;
   localparam int unsigned LPT_SPAN   = 2;
   localparam int unsigned RK_SPAN    = 4;
   localparam int unsigned DW_SPAN    = 5;
   localparam int unsigned RX_SPAN    = 2;
   localparam int unsigned MY_SPAN    = 2;
   localparam int unsigned KGD_SPAN   = 3;

   //****************************************
   // counts and indices
   //****************************************
   localparam int unsigned N_IO = 8;    // i/o page devices
   localparam int unsigned N_SD = 4;    // sd card users

   // card users, index order is also grant priority
   localparam int unsigned SD_RK = 0;
   localparam int unsigned SD_DW = 1;
   localparam int unsigned SD_DX = 2;
   localparam int unsigned SD_MY = 3;

   localparam int unsigned SD_FILTER_DEPTH = 2;  // request sync stages

   // card lines while nobody holds the card
   localparam logic SD_DEF_CS   = 1'b1;   // deselected
   localparam logic SD_DEF_MOSI = 1'b1;   // idle high
   localparam logic SD_DEF_SCLK = 1'b0;

   //****************************************
   // types
   //****************************************
   typedef struct packed {
      logic              cyc;    // cycle open
      logic              stb;    // transfer strobe
      logic              we;     // 1 = write
      logic [SEL_W-1:0]  sel;    // byte lanes
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;    // write data
   } bus_req_t;                  // 37 bits

   typedef struct packed {
      logic [DATA_W-1:0] dat;    // read data
      logic              ack;
   } bus_rsp_t;                  // 17 bits

   // uart1 is bit 7, kgd is bit 0 when viewed as a vector
   typedef struct packed {
      logic uart1;
      logic uart2;
      logic lpt;
      logic rk;
      logic dw;
      logic rx;
      logic my;
      logic kgd;
   } io_sel_t;

   typedef struct packed {
      logic cs;
      logic mosi;
      logic sclk;
   } spi_lines_t;

   typedef logic [N_SD-1:0] sd_vec_t;   // one bit per card user

endpackage
